// File: Makefile
# Verilator build and run of the softmax datapath testbench

VERILATOR ?= verilator
TOP       ?= tb_softmax
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG) || \
	   ! grep -q "Simulation passed" $(LOG); then \
		echo "test: FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/softmax_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timing and masking assertions for the softmax datapath,
// attached to every datapath instance by the bind at the end.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module softmax_checker (
    input logic                        clk_i,
    input logic                        rst_ni,
    input logic                        clear_i,
    input logic                        valid_i,
    input softmax_stage_pkg::beat_s    beat_i,
    input logic                        exp_valid_i,
    input softmax_stage_pkg::exp_rec_s exp_i,
    input logic                        den_valid_i
);

    import softmax_num_pkg::*;
    import softmax_stage_pkg::*;

    // A beat with no clear during its two stages reaches exp_o
    exp_follows_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_i && !clear_i) ##1 !clear_i |=> exp_valid_i)
        else $error("exp_valid_o missing two cycles after a beat");

    exp_needs_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_valid_i |-> $past(valid_i, 2))
        else $error("exp_valid_o without a beat two cycles earlier");

    den_after_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
        den_valid_i |-> $past(valid_i && beat_i.last, 4))
        else $error("den_valid_o without a last beat four cycles earlier");

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        masked_lane_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
            (exp_valid_i && !exp_i.strb[i]) |-> (exp_i.exp[i] == '0))
            else $error("masked lane %0d of exp_o is not zero", i);
    end

endmodule

bind softmax_datapath softmax_checker checker0 (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .valid_i     ( valid_i     ),
    .beat_i      ( beat_i      ),
    .exp_valid_i ( exp_valid_o ),
    .exp_i       ( exp_o       ),
    .den_valid_i ( den_valid_o )
);

// File: bench/tb_softmax.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the softmax datapath: directed tests checked
// against a reference model of the max, exponent and
// denominator rules, with a watchdog on the whole run.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_softmax;

    import softmax_num_pkg::*;
    import softmax_stage_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 12;
    localparam int N_TESTS      = 5;
    // Upper bound on the beats of all tests together
    localparam int TOTAL_BEATS  = 64;
    localparam int WATCHDOG_NS  =
        (TOTAL_BEATS + N_TESTS * DRAIN_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD;
    localparam int EXP_CUTOFF   = 16;
    localparam int DEN_CUTOFF   = 24;
    localparam int START_MAX    = -128;

    logic     clk_i;
    logic     rst_ni;
    logic     clear_i;
    logic     valid_i;
    beat_s    beat_i;
    logic     exp_valid_o;
    exp_rec_s exp_o;
    logic     den_valid_o;
    den_t     den_o;

    // Expected records tagged with the cycle their beat was driven in
    exp_rec_s    exp_q[$];
    int          exp_tag_q[$];
    den_t        den_q[$];
    int          den_tag_q[$];
    int          model_max;
    int          model_acc;
    int          cyc = 0;
    int          errors;
    int          checks;
    int          tests_run;

    softmax_datapath dut0 (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .clear_i     ( clear_i     ),
        .valid_i     ( valid_i     ),
        .beat_i      ( beat_i      ),
        .exp_valid_o ( exp_valid_o ),
        .exp_o       ( exp_o       ),
        .den_valid_o ( den_valid_o ),
        .den_o       ( den_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) cyc <= cyc + 1;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    task automatic compare_exp(input exp_rec_s got, input exp_rec_s want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR exp_o: got %h expected %h", got, want);
        end
    endtask

    task automatic compare_den(input den_t got, input den_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR den_o: got %h expected %h", got, want);
        end
    endtask

    // Output monitor pops one expected record per valid pulse
    always @(posedge clk_i) begin
        if (rst_ni && exp_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("exp_valid_o pulsed while no exponent record was expected");
            end else begin
                compare_exp(exp_o, exp_q.pop_front());
                void'(exp_tag_q.pop_front());
            end
        end
        if (rst_ni && den_valid_o) begin
            if (den_q.size() == 0) begin
                errors++;
                $display("den_valid_o pulsed while no denominator was expected");
            end else begin
                compare_den(den_o, den_q.pop_front());
                void'(den_tag_q.pop_front());
            end
        end
    end

    // Running max, base-2 exponents and rescale-then-add denominator
    task automatic model_beat(input beat_s b, input int tag);
        exp_rec_s want;
        score_t   s;
        int       lane_max;
        int       new_max;
        int       diff;
        int       shift;
        int       beat_sum;
        lane_max = START_MAX;
        beat_sum = 0;
        for (int i = 0; i < N_LANES; i++) begin
            s = b.score[i];
            if (b.strb[i] && int'(s) > lane_max) begin
                lane_max = int'(s);
            end
        end
        new_max = (lane_max > model_max) ? lane_max : model_max;
        for (int i = 0; i < N_LANES; i++) begin
            s = b.score[i];
            diff = new_max - int'(s);
            want.exp[i] = (b.strb[i] && diff < EXP_CUTOFF) ? exp_t'(EXP_ONE >> diff) : '0;
            beat_sum += int'(want.exp[i]);
        end
        shift = new_max - model_max;
        want.strb  = b.strb;
        want.last  = b.last;
        want.shift = shift_t'(shift);
        exp_q.push_back(want);
        exp_tag_q.push_back(tag);
        model_acc = (shift >= DEN_CUTOFF) ? 0 : (model_acc >> shift);
        model_acc = (model_acc + beat_sum) % (1 << DEN_CUTOFF);
        if (b.last) begin
            den_q.push_back(den_t'(model_acc));
            den_tag_q.push_back(tag);
            model_acc = 0;
            model_max = START_MAX;
        end else begin
            model_max = new_max;
        end
    endtask

    function automatic beat_s make_beat(input int s0, input int s1, input int s2,
                                        input int s3, input strb_t strb, input logic last);
        beat_s b;
        b.score[0] = score_t'(s0);
        b.score[1] = score_t'(s1);
        b.score[2] = score_t'(s2);
        b.score[3] = score_t'(s3);
        b.strb     = strb;
        b.last     = last;
        return b;
    endfunction

    function automatic beat_s random_beat(input logic last);
        beat_s b;
        for (int i = 0; i < N_LANES; i++) begin
            b.score[i] = score_t'(int'($urandom_range(40)) - 20);
        end
        b.strb = strb_t'($urandom_range(15));
        b.last = last;
        return b;
    endfunction

    task automatic drive_beat(input beat_s b);
        @(posedge clk_i);
        valid_i <= 1'b1;
        beat_i  <= b;
        model_beat(b, cyc);
    endtask

    task automatic drive_idle();
        @(posedge clk_i);
        valid_i <= 1'b0;
        beat_i  <= '0;
    endtask

    // A clear drops the exponent of the last beat and the denominators of the last three
    task automatic apply_clear();
        @(posedge clk_i);
        valid_i <= 1'b0;
        clear_i <= 1'b1;
        while (exp_tag_q.size() > 0 && exp_tag_q[$] >= cyc - 1) begin
            void'(exp_q.pop_back());
            void'(exp_tag_q.pop_back());
        end
        while (den_tag_q.size() > 0 && den_tag_q[$] >= cyc - 3) begin
            void'(den_q.pop_back());
            void'(den_tag_q.pop_back());
        end
        model_max = START_MAX;
        model_acc = 0;
        @(posedge clk_i);
        clear_i <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() > 0 || den_q.size() > 0) && n < DRAIN_CYCLES) begin
            @(negedge clk_i);
            n++;
        end
        if (exp_q.size() > 0 || den_q.size() > 0) begin
            errors++;
            $display("%0d exponent records and %0d denominators never appeared",
                     exp_q.size(), den_q.size());
            exp_q.delete();
            exp_tag_q.delete();
            den_q.delete();
            den_tag_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    task automatic test_equal_scores();
        int errs_before;
        errs_before = errors;
        drive_beat(make_beat(10, 10, 10, 10, 4'b1111, 1'b1));
        drive_idle();
        wait_drain();
        report_test("single beat, equal scores", errs_before);
    endtask

    task automatic test_strobe_masking();
        int errs_before;
        errs_before = errors;
        // Masked lane 1 holds the largest score
        drive_beat(make_beat(3, 100, -5, 3, 4'b1101, 1'b0));
        drive_beat(make_beat(50, 50, 50, 50, 4'b0000, 1'b0));
        drive_beat(make_beat(1, 2, -9, 0, 4'b0110, 1'b1));
        drive_idle();
        wait_drain();
        report_test("strobe masking", errs_before);
    endtask

    task automatic test_rising_max();
        int errs_before;
        errs_before = errors;
        drive_beat(make_beat(0, 0, -1, -2, 4'b1111, 1'b0));
        drive_beat(make_beat(2, 1, 0, 0, 4'b1111, 1'b0));
        drive_beat(make_beat(7, 3, 7, -4, 4'b1111, 1'b0));
        drive_beat(make_beat(5, 8, 1, 2, 4'b1111, 1'b1));
        drive_idle();
        wait_drain();
        report_test("rising maximum across beats", errs_before);
    endtask

    task automatic test_underflow();
        int errs_before;
        errs_before = errors;
        drive_beat(make_beat(-100, -100, -100, -100, 4'b1111, 1'b0));
        drive_beat(make_beat(-90, -100, -106, -110, 4'b1111, 1'b0));
        // Rise of 110 flushes the accumulator
        drive_beat(make_beat(20, 4, 3, -100, 4'b1111, 1'b1));
        drive_idle();
        wait_drain();
        report_test("underflow", errs_before);
    endtask

    task automatic test_rows_and_clear();
        int errs_before;
        int n_beats;
        errs_before = errors;
        for (int r = 0; r < 8; r++) begin
            n_beats = int'($urandom_range(4, 1));
            for (int k = 0; k < n_beats; k++) begin
                drive_beat(random_beat(k == n_beats - 1));
            end
        end
        for (int k = 0; k < 3; k++) begin
            drive_beat(random_beat(1'b0));
        end
        apply_clear();
        drive_beat(make_beat(5, 5, 5, 5, 4'b1111, 1'b0));
        drive_beat(make_beat(6, 2, -3, 0, 4'b1111, 1'b1));
        drive_idle();
        wait_drain();
        report_test("back-to-back rows with clear", errs_before);
    endtask

    initial begin
        void'($urandom(72));
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        model_max = START_MAX;
        model_acc = 0;
        rst_ni    = 1'b0;
        clear_i   = 1'b0;
        valid_i   = 1'b0;
        beat_i    = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        test_equal_scores();
        test_strobe_masking();
        test_rising_max();
        test_underflow();
        test_rows_and_clear();
        repeat (4) @(posedge clk_i);
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/softmax_num_pkg.sv
source/softmax_stage_pkg.sv
source/max_stage.sv
source/exp_stage.sv
source/lane_sum_stage.sv
source/denom_acc_stage.sv
source/softmax_datapath.sv
bench/softmax_checker.sv
bench/tb_softmax.sv

// File: source/denom_acc_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fourth pipeline stage. Holds the row denominator, rescales it
// whenever the row maximum rose and adds the beat sum. On the
// last beat of a row it presents the result and starts over.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module denom_acc_stage (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        clear_i,
    input  logic                        valid_i,
    input  softmax_stage_pkg::sum_rec_s rec_i,
    output logic                        den_valid_o,
    output softmax_num_pkg::den_t       den_o
);

    import softmax_num_pkg::*;
    import softmax_stage_pkg::*;

    den_t acc_q;
    den_t acc_scaled;
    den_t acc_next;

    // Old terms were taken against a smaller max, scale by 2^-shift
    assign acc_scaled = (rec_i.shift >= shift_t'(DEN_W)) ? '0 : (acc_q >> rec_i.shift);
    assign acc_next   = acc_scaled + den_t'(rec_i.sum);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            acc_q <= '0;
        end else if (clear_i) begin
            acc_q <= '0;
        end else if (valid_i) begin
            acc_q <= rec_i.last ? '0 : acc_next;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            den_valid_o <= 1'b0;
        end else begin
            den_valid_o <= valid_i & rec_i.last & ~clear_i;
        end
    end

    // Result holds until the next row completes
    always_ff @(posedge clk_i) begin
        if (valid_i && rec_i.last) begin
            den_o <= acc_next;
        end
    end

endmodule

// File: source/exp_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Second pipeline stage. Forms the base-2 exponent of every lane
// against the new running maximum and the rescale shift of the
// denominator. Its output is also the exponent output of the top.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module exp_stage (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        clear_i,
    input  logic                        valid_i,
    input  softmax_stage_pkg::max_rec_s rec_i,
    output logic                        valid_o,
    output softmax_stage_pkg::exp_rec_s rec_o
);

    import softmax_num_pkg::*;
    import softmax_stage_pkg::*;

    exp_rec_s rec_d;

    // hi - lo with both sign extended, only used where hi >= lo
    function automatic shift_t score_diff(score_t hi, score_t lo);
        logic signed [SCORE_W:0] wide;
        wide = {hi[SCORE_W-1], hi} - {lo[SCORE_W-1], lo};
        return shift_t'(wide);
    endfunction

    always_comb begin
        shift_t lane_diff;
        for (int i = 0; i < N_LANES; i++) begin
            lane_diff = score_diff(rec_i.new_max, rec_i.score[i]);
            if (rec_i.strb[i] && (lane_diff < shift_t'(EXP_LIMIT))) begin
                rec_d.exp[i] = EXP_ONE >> lane_diff;
            end else begin
                // Underflow or masked lane
                rec_d.exp[i] = '0;
            end
        end
        rec_d.strb  = rec_i.strb;
        rec_d.last  = rec_i.last;
        rec_d.shift = score_diff(rec_i.new_max, rec_i.old_max);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i & ~clear_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rec_o <= rec_d;
    end

endmodule

// File: source/lane_sum_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Third pipeline stage. Adds the lane exponents of one beat in a
// two-level adder tree and forwards the sum with last and shift.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module lane_sum_stage (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        clear_i,
    input  logic                        valid_i,
    input  softmax_stage_pkg::exp_rec_s rec_i,
    output logic                        valid_o,
    output softmax_stage_pkg::sum_rec_s rec_o
);

    import softmax_num_pkg::*;
    import softmax_stage_pkg::*;

    logic [EXP_W:0] pair_sum [N_LANES/2];
    sum_rec_s       rec_d;

    // First level, neighbouring lanes
    always_comb begin
        for (int p = 0; p < N_LANES / 2; p++) begin
            pair_sum[p] = {1'b0, rec_i.exp[2*p]} + {1'b0, rec_i.exp[2*p+1]};
        end
    end

    always_comb begin
        rec_d.sum   = sum_t'(pair_sum[0]) + sum_t'(pair_sum[1]);
        rec_d.last  = rec_i.last;
        rec_d.shift = rec_i.shift;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i & ~clear_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rec_o <= rec_d;
    end

endmodule

// File: source/max_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First pipeline stage. Takes the maximum over the strobed lanes,
// folds it into the running row maximum and passes the beat on
// with the old and the new maximum one cycle later.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module max_stage (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        clear_i,
    input  logic                        valid_i,
    input  softmax_stage_pkg::beat_s    beat_i,
    output logic                        valid_o,
    output softmax_stage_pkg::max_rec_s rec_o
);

    import softmax_num_pkg::*;
    import softmax_stage_pkg::*;

    score_t   run_max_q;
    score_t   lane_max;
    score_t   new_max;
    max_rec_s rec_d;

    // Masked lanes do not take part in the maximum
    always_comb begin
        score_t lane_score;
        lane_max = SCORE_MIN;
        for (int i = 0; i < N_LANES; i++) begin
            lane_score = beat_i.score[i];
            if (beat_i.strb[i] && (lane_score > lane_max)) begin
                lane_max = lane_score;
            end
        end
    end

    assign new_max = (lane_max > run_max_q) ? lane_max : run_max_q;

    always_comb begin
        rec_d.score   = beat_i.score;
        rec_d.strb    = beat_i.strb;
        rec_d.last    = beat_i.last;
        rec_d.old_max = run_max_q;
        rec_d.new_max = new_max;
    end

    // Running row maximum, restarts after the last beat of a row
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            run_max_q <= SCORE_MIN;
        end else if (clear_i) begin
            run_max_q <= SCORE_MIN;
        end else if (valid_i) begin
            run_max_q <= beat_i.last ? SCORE_MIN : new_max;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i & ~clear_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rec_o <= rec_d;
    end

endmodule

// File: source/softmax_datapath.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streaming softmax front end. Chains max, exponent, lane sum and
// denominator stages; exponents appear 2 cycles after a beat and
// the row denominator 4 cycles after the last beat of a row.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module softmax_datapath (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        clear_i,
    input  logic                        valid_i,
    input  softmax_stage_pkg::beat_s    beat_i,
    output logic                        exp_valid_o,
    output softmax_stage_pkg::exp_rec_s exp_o,
    output logic                        den_valid_o,
    output softmax_num_pkg::den_t       den_o
);

    import softmax_stage_pkg::*;

    logic     max_valid;
    max_rec_s max_rec;
    logic     sum_valid;
    sum_rec_s sum_rec;

    max_stage i_max_stage (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .clear_i ( clear_i   ),
        .valid_i ( valid_i   ),
        .beat_i  ( beat_i    ),
        .valid_o ( max_valid ),
        .rec_o   ( max_rec   )
    );

    // Exponent record is tapped here as the datapath output
    exp_stage i_exp_stage (
        .clk_i   ( clk_i       ),
        .rst_ni  ( rst_ni      ),
        .clear_i ( clear_i     ),
        .valid_i ( max_valid   ),
        .rec_i   ( max_rec     ),
        .valid_o ( exp_valid_o ),
        .rec_o   ( exp_o       )
    );

    lane_sum_stage i_lane_sum_stage (
        .clk_i   ( clk_i       ),
        .rst_ni  ( rst_ni      ),
        .clear_i ( clear_i     ),
        .valid_i ( exp_valid_o ),
        .rec_i   ( exp_o       ),
        .valid_o ( sum_valid   ),
        .rec_o   ( sum_rec     )
    );

    denom_acc_stage i_denom_acc_stage (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .clear_i     ( clear_i     ),
        .valid_i     ( sum_valid   ),
        .rec_i       ( sum_rec     ),
        .den_valid_o ( den_valid_o ),
        .den_o       ( den_o       )
    );

endmodule

// File: source/softmax_num_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Numeric formats of the softmax front end: lane count, score,
// exponent, sum and denominator widths and fixed-point constants.
// Imported by every pipeline stage and by the stage records.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package softmax_num_pkg;

    // Scores per beat
    localparam int unsigned N_LANES = 4;

    // Signed attention scores
    localparam int unsigned SCORE_W = 8;
    typedef logic signed [SCORE_W-1:0] score_t;
    localparam score_t SCORE_MIN = {1'b1, {(SCORE_W-1){1'b0}}};

    // Max minus score never exceeds the score range, one extra bit
    localparam int unsigned SHIFT_W = SCORE_W + 1;
    typedef logic [SHIFT_W-1:0] shift_t;

    // Exponent in unsigned fixed point, 15 fraction bits
    localparam int unsigned EXP_W = 16;
    localparam int unsigned EXP_FRAC = 15;
    typedef logic [EXP_W-1:0] exp_t;
    localparam exp_t EXP_ONE = exp_t'(1) << EXP_FRAC;

    // Shifts from here on push the one out of the word
    localparam int unsigned EXP_LIMIT = EXP_FRAC + 1;

    // Sum of the four lane exponents of one beat
    localparam int unsigned SUM_W = 18;
    typedef logic [SUM_W-1:0] sum_t;

    // Row denominator
    localparam int unsigned DEN_W = 24;
    typedef logic [DEN_W-1:0] den_t;

    // One strobe bit per lane
    typedef logic [N_LANES-1:0] strb_t;

endpackage

// File: source/softmax_stage_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Records of the softmax pipeline: the input beat, the records
// handed from stage to stage and the exponent output record.
// Each record travels next to its own one-bit valid strobe.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package softmax_stage_pkg;

    import softmax_num_pkg::*;

    // Input beat, last marks the final beat of a row
    typedef struct packed {
        score_t [N_LANES-1:0] score;
        strb_t                strb;
        logic                 last;
    } beat_s;

    // Stage 1 to stage 2, running max before and after this beat
    typedef struct packed {
        score_t [N_LANES-1:0] score;
        strb_t                strb;
        logic                 last;
        score_t               old_max;
        score_t               new_max;
    } max_rec_s;

    // Stage 2 to stage 3, also the exponent output of the datapath
    typedef struct packed {
        exp_t [N_LANES-1:0] exp;
        strb_t              strb;
        logic               last;
        shift_t             shift;
    } exp_rec_s;

    // Stage 3 to stage 4
    typedef struct packed {
        sum_t   sum;
        logic   last;
        shift_t shift;
    } sum_rec_s;

endpackage
